/* dprx_top.f */
rtl/dprx_pkg.sv
rtl/dprx_descrambler.sv
rtl/dprx_stream_parser.sv
rtl/dprx_msa_capture.sv
rtl/dprx_host_regs.sv
rtl/dprx_top.sv
test/tb_clk_gen.sv
test/tb_dprx_top.sv

/* rtl/dprx_descrambler.sv */
// One LFSR per lane, reseeded by SR; lanes must already be aligned
// Lock needs two SR symbols on every lane after lnk_en goes high
`timescale 1ns/1ps

module dprx_descrambler import dprx_pkg::*;
(
    input  logic      lnk_clk,
    input  logic      rst_n,
    input  logic      lnk_en,
    input  lnk_word_t lnk_in,
    output lnk_word_t dsc_word,
    output logic      scrm_lock
);

    logic [LFSR_W-1:0] lfsr     [LANES];   // Current state per lane
    logic [LFSR_W-1:0] lfsr_nxt [LANES];   // State after 8 steps
    logic [SYM_W-1:0]  ks       [LANES];   // Keystream byte for this symbol
    logic [1:0]        sr_cnt   [LANES];   // Saturating SR count
    logic [LANES-1:0]  is_sr;
    logic [LANES-1:0]  lane_lock;

    // Eight Galois steps, keystream taken from the MSB, bit 0 first
    function automatic logic [SYM_W+LFSR_W-1:0] lfsr_step8(input logic [LFSR_W-1:0] s);
        logic [LFSR_W-1:0] l;
        logic [SYM_W-1:0]  k;
        l = s;
        for (int b = 0; b < SYM_W; b++)
        begin
            k[b] = l[LFSR_W-1];
            l    = {l[LFSR_W-2:0], 1'b0} ^ (l[LFSR_W-1] ? LFSR_TAPS : '0);
        end
        return {k, l};
    endfunction

    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            is_sr[i]              = lnk_in.sym[i].k && (lnk_in.sym[i].dat == K_SR);
            {ks[i], lfsr_nxt[i]}  = lfsr_step8(lfsr[i]);
            lane_lock[i]          = (sr_cnt[i] == 2'(SR_LOCK_CNT));
        end
    end

    assign scrm_lock = &lane_lock;  // All lanes saw enough SRs

    // LFSR and lock tracking
    always_ff @(posedge lnk_clk)
    begin
        for (int i = 0; i < LANES; i++)
        begin
            if (!rst_n || !lnk_en)
            begin
                lfsr[i]   <= LFSR_SEED;
                sr_cnt[i] <= '0;
            end
            else if (is_sr[i])
            begin
                lfsr[i] <= LFSR_SEED;   // Seed, no advance on SR itself
                if (!lane_lock[i])
                    sr_cnt[i] <= sr_cnt[i] + 2'd1;
            end
            else
                lfsr[i] <= lfsr_nxt[i];  // Every other symbol, K included
        end
    end

    // Output word, K symbols untouched
    always_ff @(posedge lnk_clk)
    begin
        for (int i = 0; i < LANES; i++)
        begin
            dsc_word.sym[i].k   <= lnk_in.sym[i].k;
            dsc_word.sym[i].dat <= lnk_in.sym[i].k ? lnk_in.sym[i].dat
                                                   : lnk_in.sym[i].dat ^ ks[i];
        end
    end

endmodule

/* rtl/dprx_host_regs.sv */
// Host strobes are one cycle wide, wr and rd never together
// Status read clears the sticky irq unless a new MSA arrives that cycle
`timescale 1ns/1ps

module dprx_host_regs import dprx_pkg::*;
(
    input  logic              lnk_clk,
    input  logic              rst_n,
    input  host_req_t         host,
    output logic [REG_DW-1:0] host_rdat,
    output logic              host_irq,
    output logic              hpd,
    output logic              lnk_en,
    input  logic              scrm_lock,
    input  logic              vid_en,
    input  msa_t              msa,
    input  logic              msa_irq
);

    logic              irq_sticky;
    logic              sta_rd;      // Status read this cycle
    logic [REG_DW-1:0] rd_mux;

    assign sta_rd   = host.rd && (host.addr == REG_STATUS);
    assign host_irq = irq_sticky;

    // Control register and sticky interrupt
    always_ff @(posedge lnk_clk)
    begin
        if (!rst_n)
        begin
            lnk_en     <= 1'b0;
            hpd        <= 1'b0;
            irq_sticky <= 1'b0;
        end
        else
        begin
            if (host.wr && host.addr == REG_CTRL)
            begin
                lnk_en <= host.wdat[0];
                hpd    <= host.wdat[1];
            end
            if (msa_irq)
                irq_sticky <= 1'b1;     // Set wins over clear
            else if (sta_rd)
                irq_sticky <= 1'b0;
        end
    end

    // Read decode
    always_comb
    begin
        rd_mux = '0;
        case (host.addr)
            REG_CTRL:
            begin
                rd_mux[0] = lnk_en;
                rd_mux[1] = hpd;
            end
            REG_STATUS:
            begin
                rd_mux[0] = scrm_lock;
                rd_mux[1] = vid_en;
                rd_mux[2] = irq_sticky;     // Value before the clear
            end
            REG_MSA_BASE:                rd_mux = msa.htotal;
            REG_MSA_BASE + REG_AW'(1):   rd_mux = msa.vtotal;
            REG_MSA_BASE + REG_AW'(2):   rd_mux = msa.hactive;
            REG_MSA_BASE + REG_AW'(3):   rd_mux = msa.vactive;
            default:                     rd_mux = '0;
        endcase
    end

    // Read data holds until the next read
    always_ff @(posedge lnk_clk)
    begin
        if (host.rd)
            host_rdat <= rd_mux;
    end

endmodule

/* rtl/dprx_msa_capture.sv */
// MSA packet is SS SS, four 16-bit words, then SE, all on both lanes
// Early K symbol drops the packet and keeps the last good values
`timescale 1ns/1ps

module dprx_msa_capture import dprx_pkg::*;
(
    input  logic      lnk_clk,
    input  logic      rst_n,
    input  logic      lnk_en,
    input  lnk_word_t dsc_word,
    output msa_t      msa,
    output logic      msa_irq
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SS1,
        ST_DATA,
        ST_SE
    } mst_t;

    mst_t                           state;
    logic [$clog2(MSA_WORDS)-1:0]   cnt;        // Word index within packet
    msa_t                           shadow;     // Packet under capture
    logic [REG_DW-1:0]              word_dat;
    logic                           ss_both;
    logic                           se_both;
    logic                           any_k;

    assign word_dat = {dsc_word.sym[1].dat, dsc_word.sym[0].dat};
    assign any_k    = dsc_word.sym[0].k || dsc_word.sym[1].k;
    assign ss_both  = dsc_word.sym[0].k && (dsc_word.sym[0].dat == K_SS)
                   && dsc_word.sym[1].k && (dsc_word.sym[1].dat == K_SS);
    assign se_both  = dsc_word.sym[0].k && (dsc_word.sym[0].dat == K_SE)
                   && dsc_word.sym[1].k && (dsc_word.sym[1].dat == K_SE);

    always_ff @(posedge lnk_clk)
    begin
        if (!rst_n || !lnk_en)
        begin
            state   <= ST_IDLE;
            cnt     <= '0;
            msa_irq <= 1'b0;
        end
        else
        begin
            msa_irq <= 1'b0;    // One-cycle pulse
            case (state)
                ST_IDLE:
                    if (ss_both)
                        state <= ST_SS1;
                ST_SS1:
                begin
                    cnt   <= '0;
                    state <= ss_both ? ST_DATA : ST_IDLE;
                end
                ST_DATA:
                    if (any_k)
                        state <= ST_IDLE;   // Abort, no pulse
                    else
                    begin
                        cnt <= cnt + 1'b1;
                        if (cnt == $bits(cnt)'(MSA_WORDS - 1))
                            state <= ST_SE;
                    end
                ST_SE:
                begin
                    state   <= ST_IDLE;
                    msa_irq <= se_both;     // Anything else drops the packet
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // Capture words, commit on a complete packet
    always_ff @(posedge lnk_clk)
    begin
        if (state == ST_DATA && !any_k)
            case (cnt)
                2'd0:    shadow.htotal  <= word_dat;
                2'd1:    shadow.vtotal  <= word_dat;
                2'd2:    shadow.hactive <= word_dat;
                default: shadow.vactive <= word_dat;
            endcase
        if (state == ST_SE && se_both)
            msa <= shadow;
    end

endmodule

/* rtl/dprx_pkg.sv */
// Two-lane receiver with lanes already aligned and 8b/10b decoded upstream
// Control codes are the 8-bit data value sent with the K flag set
package dprx_pkg;

    // Link and video sizes
    localparam int LANES     = 2;
    localparam int SYM_W     = 8;
    localparam int VID_W     = LANES * SYM_W;     // Lane 0 in the low byte
    localparam int MSA_WORDS = 4;

    // Host bus
    localparam int REG_AW = 4;
    localparam int REG_DW = 16;

    // Scrambler, X^16+X^5+X^4+X^3+1
    localparam int                LFSR_W      = 16;
    localparam logic [LFSR_W-1:0] LFSR_SEED   = 16'hFFFF;
    localparam logic [LFSR_W-1:0] LFSR_TAPS   = 16'h0039;  // Taps 5, 4, 3 and 0
    localparam int                SR_LOCK_CNT = 2;         // SR rounds per lane for lock

    // K codes
    localparam logic [SYM_W-1:0] K_BS = 8'hBC;    // Blanking start
    localparam logic [SYM_W-1:0] K_BE = 8'hFB;    // Blanking end
    localparam logic [SYM_W-1:0] K_SR = 8'h1C;    // Scrambler reset
    localparam logic [SYM_W-1:0] K_SS = 8'h5C;    // Secondary start
    localparam logic [SYM_W-1:0] K_SE = 8'hFD;    // Secondary end

    // Register map
    localparam logic [REG_AW-1:0] REG_CTRL     = 4'd0;
    localparam logic [REG_AW-1:0] REG_STATUS   = 4'd1;
    localparam logic [REG_AW-1:0] REG_MSA_BASE = 4'd2;  // htotal, vtotal, hactive, vactive

    typedef struct packed {
        logic             k;
        logic [SYM_W-1:0] dat;
    } lnk_sym_t;

    typedef struct packed {
        lnk_sym_t [LANES-1:0] sym;
    } lnk_word_t;

    typedef struct packed {
        logic             vld;
        logic             sof;
        logic             eol;
        logic [VID_W-1:0] dat;
    } vid_beat_t;

    typedef struct packed {
        logic [REG_DW-1:0] htotal;
        logic [REG_DW-1:0] vtotal;
        logic [REG_DW-1:0] hactive;
        logic [REG_DW-1:0] vactive;
    } msa_t;

    typedef struct packed {
        logic              wr;
        logic              rd;
        logic [REG_AW-1:0] addr;
        logic [REG_DW-1:0] wdat;
    } host_req_t;

endpackage

/* rtl/dprx_stream_parser.sv */
// BS/BE framing on lane 0; VB-ID is the single word after BS
// No back-pressure; beats leave as a plain valid strobe two cycles after input
`timescale 1ns/1ps

module dprx_stream_parser import dprx_pkg::*;
(
    input  logic      lnk_clk,
    input  logic      rst_n,
    input  logic      lnk_en,
    input  logic      scrm_lock,
    input  lnk_word_t dsc_word,
    output vid_beat_t vid,
    output logic      vid_en
);

    typedef enum logic [1:0] {
        ST_BLANK,
        ST_VBID,
        ST_ACTIVE
    } pst_t;

    typedef struct packed {
        logic             vld;
        logic             sof;
        logic [VID_W-1:0] dat;
    } pend_t;

    pst_t             state;
    pend_t            pend;         // Held beat until eol is known
    logic             vb_seen;      // VB-ID with vblank set seen
    logic             sof_arm;      // Vblank ended, next line starts a frame
    logic             first_beat;   // Nothing sent yet since BE
    logic [LANES-1:0] k_bits;
    logic             bs_now;
    logic             be_now;
    logic             beat_now;
    logic [VID_W-1:0] word_dat;

    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            k_bits[i]                    = dsc_word.sym[i].k;
            word_dat[i*SYM_W +: SYM_W]   = dsc_word.sym[i].dat;  // Lane 0 low byte
        end
    end

    assign bs_now   = dsc_word.sym[0].k && (dsc_word.sym[0].dat == K_BS);
    assign be_now   = dsc_word.sym[0].k && (dsc_word.sym[0].dat == K_BE);
    assign beat_now = (state == ST_ACTIVE) && (k_bits == '0);  // All data symbols

    always_ff @(posedge lnk_clk)
    begin
        if (!rst_n || !lnk_en)
        begin
            state      <= ST_BLANK;
            vb_seen    <= 1'b0;
            sof_arm    <= 1'b0;
            first_beat <= 1'b0;
            vid_en     <= 1'b0;
            pend       <= '0;
            vid        <= '0;
        end
        else
        begin
            // Stage 1 captures the beat
            pend.vld <= beat_now;
            pend.sof <= beat_now && first_beat && sof_arm;
            pend.dat <= word_dat;

            // Stage 2 tags eol when BS follows the held beat
            vid.vld <= pend.vld;
            vid.sof <= pend.sof;
            vid.eol <= pend.vld && bs_now;
            vid.dat <= pend.dat;

            if (beat_now)
            begin
                first_beat <= 1'b0;
                if (first_beat)
                    sof_arm <= 1'b0;    // Frame start consumed
            end

            if (bs_now)
                state <= ST_VBID;       // Line over
            else if (be_now)
            begin
                state      <= ST_ACTIVE;
                first_beat <= 1'b1;
                if (scrm_lock)
                    vid_en <= 1'b1;
            end
            else if (state == ST_VBID)
            begin
                state <= ST_BLANK;
                if (dsc_word.sym[0].dat[0])
                begin
                    vb_seen <= 1'b1;    // In vertical blanking
                    sof_arm <= 1'b0;
                end
                else if (vb_seen)
                begin
                    vb_seen <= 1'b0;    // Vblank just ended
                    sof_arm <= 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/dprx_top.sv */
// Single link clock for host, link and video; no AUX, training or deskew
// Video has no ready, beats must be taken as they come
`timescale 1ns/1ps

module dprx_top import dprx_pkg::*;
(
    input  logic              lnk_clk,
    input  logic              rst_n,
    input  lnk_word_t         lnk_in,
    input  host_req_t         host,
    output logic [REG_DW-1:0] host_rdat,
    output logic              host_irq,
    output logic              hpd,
    output logic              scrm_lock,
    output vid_beat_t         vid
);

    lnk_word_t dsc_word;    // Descrambled lane word
    msa_t      msa;
    logic      msa_irq;
    logic      lnk_en;      // From control register
    logic      vid_en;

    dprx_descrambler u_descrambler (
        .lnk_clk   (lnk_clk),
        .rst_n     (rst_n),
        .lnk_en    (lnk_en),
        .lnk_in    (lnk_in),
        .dsc_word  (dsc_word),
        .scrm_lock (scrm_lock)
    );

    dprx_stream_parser u_stream_parser (
        .lnk_clk   (lnk_clk),
        .rst_n     (rst_n),
        .lnk_en    (lnk_en),
        .scrm_lock (scrm_lock),
        .dsc_word  (dsc_word),
        .vid       (vid),
        .vid_en    (vid_en)
    );

    dprx_msa_capture u_msa_capture (
        .lnk_clk   (lnk_clk),
        .rst_n     (rst_n),
        .lnk_en    (lnk_en),
        .dsc_word  (dsc_word),
        .msa       (msa),
        .msa_irq   (msa_irq)
    );

    // Stands in for the policy maker
    dprx_host_regs u_host_regs (
        .lnk_clk   (lnk_clk),
        .rst_n     (rst_n),
        .host      (host),
        .host_rdat (host_rdat),
        .host_irq  (host_irq),
        .hpd       (hpd),
        .lnk_en    (lnk_en),
        .scrm_lock (scrm_lock),
        .vid_en    (vid_en),
        .msa       (msa),
        .msa_irq   (msa_irq)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the DisplayPort receive testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f dprx_top.f \
    --top-module tb_dprx_top \
    -o tb_dprx_top

./obj_dir/tb_dprx_top | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

/* test/dprx_patterns.txt */
// Record TXDDDD: T type, X nibble, DDDD 16-bit data. 1 link word (X k flags, D lane1 lane0)
// 2 beat (X sof eol), 3 write, 4 read (X addr), 5 levels, 6 idle (X cycles), 7 section X
700000
500000
400000
710000
300003
131C1C
131C1C
620000
500006
410001
720000
131C1C
13BCBC
101616
131C1C
13BCBC
101717
131C1C
13FBFB
100506
10E2E1
13BCBC
10B2B2
131C1C
13FBFB
102526
108281
13BCBC
10B2B2
221211
212221
203231
214241
640000
410003
730000
131C1C
135C5C
135C5C
10C3E0
101619
10B032
10E607
13FDFD
640000
500007
420320
43020D
440280
4501E0
410007
500006
740000
131C1C
135C5C
135C5C
105555
131C1C
13FDFD
640000
500006
420320
4501E0
410003
750000
300002
620000
500002
410000
131C1C
13FBFB
101111
102222
13BCBC
640000
400002

/* test/tb_clk_gen.sv */
// Free-running link clock, 10 ns period, starts low
`timescale 1ns/1ps

module tb_clk_gen
(
    output logic clk
);

    initial
        clk = 1'b0;

    always #5 clk = ~clk;   // Half period

endmodule

/* test/tb_dprx_top.sv */
// Stimulus and expected values come from test/dprx_patterns.txt, run from project root
// Lane words are pre-scrambled; beats are checked in order rather than at fixed cycles
`timescale 1ns/1ps

module tb_dprx_top import dprx_pkg::*;
();

    localparam int PAT_DEPTH = 128;

    logic              lnk_clk;
    logic              rst_n;
    lnk_word_t         lnk_in;
    host_req_t         host;
    logic [REG_DW-1:0] host_rdat;
    logic              host_irq;
    logic              hpd;
    logic              scrm_lock;
    vid_beat_t         vid;

    logic [23:0]       pat [PAT_DEPTH];
    logic [17:0]       exp_q [$];       // {sof, eol, dat}
    int                errors;
    int                checks;
    int                seed;
    int                wd_cycles;
    logic              loaded;
    string             test_name;

    tb_clk_gen u_clk_gen (.clk(lnk_clk));

    dprx_top u_dut (
        .lnk_clk   (lnk_clk),
        .rst_n     (rst_n),
        .lnk_in    (lnk_in),
        .host      (host),
        .host_rdat (host_rdat),
        .host_irq  (host_irq),
        .hpd       (hpd),
        .scrm_lock (scrm_lock),
        .vid       (vid)
    );

    function automatic string section_name(input logic [3:0] n);
        case (n)
            4'd0:    return "reset_quiet";
            4'd1:    return "scrambler_lock";
            4'd2:    return "video_frame";
            4'd3:    return "msa_capture";
            4'd4:    return "msa_abort";
            default: return "link_disable";
        endcase
    endfunction

    task automatic drive_link(input logic [23:0] r);
        @(posedge lnk_clk);
        lnk_in.sym[1] <= {r[17], r[15:8]};
        lnk_in.sym[0] <= {r[16], r[7:0]};
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge lnk_clk);
            lnk_in <= '0;   // Zero data words are ignored in blanking
        end
    endtask

    // Random idle gap before each host access
    task automatic host_gap();
        int gap;
        gap = $random(seed) & 3;
        idle_cycles(gap);
    endtask

    task automatic host_write(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] wdat);
        host_gap();
        @(posedge lnk_clk);
        lnk_in <= '0;
        host   <= {1'b1, 1'b0, addr, wdat};
        @(posedge lnk_clk);
        host   <= '0;
    endtask

    task automatic host_read(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] exp);
        host_gap();
        @(posedge lnk_clk);
        lnk_in <= '0;
        host   <= {1'b0, 1'b1, addr, {REG_DW{1'b0}}};
        @(posedge lnk_clk);
        host   <= '0;
        @(negedge lnk_clk);     // Read data registered on the last edge
        checks++;
        assert (host_rdat == exp)
        else
        begin
            errors++;
            $display("[FAIL] %s: reg %0d expected %h actual %h",
                     test_name, addr, exp, host_rdat);
        end
    endtask

    // Bit 2 scrm_lock, bit 1 hpd, bit 0 host_irq
    task automatic check_levels(input logic [2:0] exp);
        @(negedge lnk_clk);
        checks++;
        assert ({scrm_lock, hpd, host_irq} == exp)
        else
        begin
            errors++;
            $display("[FAIL] %s: levels expected %b actual %b",
                     test_name, exp, {scrm_lock, hpd, host_irq});
        end
    endtask

    // Beat monitor samples mid-cycle
    always @(negedge lnk_clk)
    begin
        logic [17:0] e;
        if (rst_n && vid.vld)
        begin
            checks++;
            assert (exp_q.size() != 0)
            else
            begin
                errors++;
                $display("Unexpected video beat %h in %s", vid.dat, test_name);
            end
            if (exp_q.size() != 0)
            begin
                e = exp_q.pop_front();
                assert ({vid.sof, vid.eol, vid.dat} == e)
                else
                begin
                    errors++;
                    $display("[FAIL] %s: beat expected %h actual %h",
                             test_name, e, {vid.sof, vid.eol, vid.dat});
                end
            end
        end
    end

    // Watchdog sized from the loaded records
    initial
    begin
        wait (loaded);
        #(wd_cycles * 10);
        $display("Watchdog expired, run did not finish in %0d cycles", wd_cycles);
        $display("Checks run %0d, errors %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        lnk_in    = '0;
        host      = '0;
        rst_n     = 1'b0;
        errors    = 0;
        checks    = 0;
        seed      = 32'h1bbaaeae;
        loaded    = 1'b0;
        test_name = "reset_quiet";
        wd_cycles = 105;    // Reset plus margin
        for (int i = 0; i < PAT_DEPTH; i++)
            pat[i] = '0;
        $readmemh("test/dprx_patterns.txt", pat);

        // Preload beats and add up the cycle cost
        for (int i = 0; i < PAT_DEPTH && pat[i][23:20] != 4'h0; i++)
        begin
            case (pat[i][23:20])
                4'h1:    wd_cycles += 1;
                4'h2:    exp_q.push_back(pat[i][17:0]);
                4'h3:    wd_cycles += 5;
                4'h4:    wd_cycles += 6;
                4'h5:    wd_cycles += 1;
                4'h6:    wd_cycles += int'(pat[i][19:16]);
                default: wd_cycles += 0;
            endcase
        end
        loaded = 1'b1;

        repeat (5) @(posedge lnk_clk);
        rst_n <= 1'b1;

        for (int i = 0; i < PAT_DEPTH && pat[i][23:20] != 4'h0; i++)
        begin
            case (pat[i][23:20])
                4'h1:    drive_link(pat[i]);
                4'h3:    host_write(pat[i][19:16], pat[i][15:0]);
                4'h4:    host_read(pat[i][19:16], pat[i][15:0]);
                4'h5:    check_levels(pat[i][2:0]);
                4'h6:    idle_cycles(int'(pat[i][19:16]));
                4'h7:    test_name = section_name(pat[i][19:16]);
                default: ;  // Beats already queued
            endcase
        end
        idle_cycles(5);     // Drain the pipeline

        checks++;
        assert (exp_q.size() == 0)
        else
        begin
            errors++;
            $display("%0d expected video beats never arrived", exp_q.size());
        end

        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
